// ==== source/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // fetch targets
    localparam logic [31:0] reset_vector   = 32'hBFC0_0000;
    localparam logic [31:0] refill_vector  = 32'hBFC0_0200;
    localparam logic [31:0] general_vector = 32'hBFC0_0380;

    // exception codes raised on fetch
    localparam logic [4:0] exc_adel = 5'd4;
    localparam logic [4:0] exc_tlbl = 5'd2;

    // redirect_kind encoding
    localparam logic [2:0] redirect_exception = 3'd0;
    localparam logic [2:0] redirect_refill    = 3'd1;
    localparam logic [2:0] redirect_eret      = 3'd2;
    localparam logic [2:0] redirect_refetch   = 3'd3;
    localparam logic [2:0] redirect_branch    = 3'd4;

    // instruction tlb geometry
    localparam int tlb_entries     = 4;
    localparam int tlb_index_width = 2;

    // k0 / c value that selects a cached access
    localparam logic [2:0] cache_cacheable = 3'd3;

endpackage

`default_nettype wire

// ==== source/itlb.sv ====
`timescale 1ns/1ns
`default_nettype none

module itlb import fetch_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       we,
    input  logic [tlb_index_width-1:0] windex,
    input  logic [18:0]                wvpn2,
    input  logic [19:0]                wpfn0,
    input  logic [19:0]                wpfn1,
    input  logic                       wv0,
    input  logic                       wv1,
    input  logic [2:0]                 wc,
    input  logic [18:0]                vpn2,
    input  logic                       odd_page,
    output logic                       found,
    output logic                       v,
    output logic [19:0]                pfn,
    output logic [2:0]                 c
);

    logic [18:0]            e_vpn2 [tlb_entries];
    logic [19:0]            e_pfn0 [tlb_entries];
    logic [19:0]            e_pfn1 [tlb_entries];
    logic [2:0]             e_c    [tlb_entries];
    logic [tlb_entries-1:0] e_v0;
    logic [tlb_entries-1:0] e_v1;

    // reset invalidates every entry
    always_ff @(posedge clk) begin
        if (reset) begin
            e_v0 <= '0;
            e_v1 <= '0;
        end else if (we) begin
            e_v0[windex] <= wv0;
            e_v1[windex] <= wv1;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            e_vpn2[windex] <= wvpn2;
            e_pfn0[windex] <= wpfn0;
            e_pfn1[windex] <= wpfn1;
            e_c[windex]    <= wc;
        end
    end

    // an entry with both halves invalid never matches, so a cleared slot reads as a miss
    always_comb begin
        found = 1'b0;
        v     = 1'b0;
        pfn   = '0;
        c     = '0;
        for (int i = 0; i < tlb_entries; i++) begin
            if ((e_vpn2[i] == vpn2) && (e_v0[i] | e_v1[i])) begin
                found = 1'b1;
                v     = odd_page ? e_v1[i] : e_v0[i];
                pfn   = odd_page ? e_pfn1[i] : e_pfn0[i];
                c     = e_c[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/addr_trans.sv ====
`timescale 1ns/1ns
`default_nettype none

module addr_trans import fetch_pkg::*; (
    input  logic [31:0] vaddr,
    input  logic [19:0] pfn,
    input  logic        found,
    input  logic        v,
    input  logic [2:0]  c,
    input  logic [2:0]  config_k0,
    output logic [31:0] paddr,
    output logic        mapped,
    output logic        cached,
    output logic [18:0] vpn2,
    output logic        odd_page
);

    logic kseg0;
    logic kseg1;

    assign kseg0  = (vaddr[31:29] == 3'b100);
    assign kseg1  = (vaddr[31:29] == 3'b101);
    assign mapped = ~(kseg0 | kseg1);

    // lookup key for the tlb, one entry covers an even and odd page pair
    assign vpn2     = vaddr[31:13];
    assign odd_page = vaddr[12];

    always_comb begin
        if (mapped) begin
            paddr  = {pfn, vaddr[11:0]};
            // a miss or invalid page faults anyway, keep the attribute quiet
            cached = found & v & (c == cache_cacheable);
        end else begin
            paddr  = {3'b000, vaddr[28:0]};
            cached = kseg0 & (config_k0 == cache_cacheable);
        end
    end

endmodule

`default_nettype wire

// ==== source/pre_if.sv ====
`timescale 1ns/1ns
`default_nettype none

module pre_if import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        redirect_valid,
    input  logic [2:0]  redirect_kind,
    input  logic [31:0] redirect_pc,
    input  logic [31:0] cp0_epc,
    input  logic        slot_free,
    input  logic        mapped,
    input  logic        found,
    input  logic        v,
    input  logic        inst_sram_addr_ok,
    output logic [31:0] fetch_vaddr,
    output logic        inst_sram_req,
    output logic        issue_accepted,
    output logic [31:0] issue_pc,
    output logic        fault_valid,
    output logic [4:0]  fault_exccode,
    output logic        fault_refill
);

    logic [31:0] pc;
    logic        started;
    logic        halted;
    logic        active;
    logic        addr_error;
    logic        tlb_error;
    logic        fault;

    // redirects take effect in the cycle they arrive
    always_comb begin
        fetch_vaddr = pc;
        if (redirect_valid) begin
            case (redirect_kind)
                redirect_exception: fetch_vaddr = general_vector;
                redirect_refill:    fetch_vaddr = refill_vector;
                redirect_eret:      fetch_vaddr = cp0_epc;
                redirect_refetch,
                redirect_branch:    fetch_vaddr = redirect_pc;
                default:            fetch_vaddr = pc;
            endcase
        end
    end

    // fault checks on the address being fetched
    assign addr_error = (fetch_vaddr[1:0] != 2'b00);
    assign tlb_error  = mapped & ~(found & v);
    assign fault      = addr_error | tlb_error;

    // a redirect restarts fetch even after a fault
    assign active = started & (~halted | redirect_valid);

    assign inst_sram_req  = active & slot_free & ~fault;
    assign issue_accepted = inst_sram_req & inst_sram_addr_ok;
    assign issue_pc       = fetch_vaddr;

    // a faulting fetch goes to if_stage as an item of its own
    assign fault_valid   = active & slot_free & fault;
    assign fault_exccode = addr_error ? exc_adel : exc_tlbl;
    assign fault_refill  = ~addr_error & mapped & ~found;

    always_ff @(posedge clk) begin
        if (reset) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (fault_valid) begin
            halted <= 1'b1;
        end else if (redirect_valid) begin
            halted <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_vector;
        end else if (issue_accepted | fault_valid) begin
            pc <= fetch_vaddr + 32'd4;
        end else if (redirect_valid) begin
            // target not issued yet, hold it until the slot frees up
            pc <= fetch_vaddr;
        end
    end

endmodule

`default_nettype wire

// ==== source/if_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module if_stage (
    input  logic        clk,
    input  logic        reset,
    input  logic        redirect_valid,
    input  logic        issue_accepted,
    input  logic [31:0] issue_pc,
    input  logic        fault_valid,
    input  logic [4:0]  fault_exccode,
    input  logic        fault_refill,
    input  logic        inst_sram_data_ok,
    input  logic [31:0] inst_sram_rdata,
    input  logic        decode_ready,
    output logic        slot_free,
    output logic        inst_valid,
    output logic [31:0] inst,
    output logic [31:0] inst_pc,
    output logic        inst_exception,
    output logic [4:0]  inst_exccode,
    output logic        inst_tlb_refill
);

    logic        outstanding;
    logic        discard;
    logic [31:0] pend_pc;
    logic        load_data;

    // the held output is either taken or flushed this cycle
    assign slot_free = ~outstanding & (~inst_valid | decode_ready | redirect_valid);

    // returning data is dropped if any redirect came after its request
    assign load_data = inst_sram_data_ok & outstanding & ~discard & ~redirect_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 1'b0;
            discard     <= 1'b0;
        end else begin
            if (issue_accepted) begin
                outstanding <= 1'b1;
                discard     <= 1'b0;
            end else if (inst_sram_data_ok) begin
                outstanding <= 1'b0;
                discard     <= 1'b0;
            end else if (redirect_valid & outstanding) begin
                discard <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_valid <= 1'b0;
        end else if (load_data | fault_valid) begin
            inst_valid <= 1'b1;
        end else if (decode_ready | redirect_valid) begin
            inst_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_accepted) begin
            pend_pc <= issue_pc;
        end
        if (load_data) begin
            inst            <= inst_sram_rdata;
            inst_pc         <= pend_pc;
            inst_exception  <= 1'b0;
            inst_exccode    <= '0;
            inst_tlb_refill <= 1'b0;
        end else if (fault_valid) begin
            // no sram access behind a fault, the word is a nop
            inst            <= '0;
            inst_pc         <= issue_pc;
            inst_exception  <= 1'b1;
            inst_exccode    <= fault_exccode;
            inst_tlb_refill <= fault_refill;
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_unit import fetch_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       redirect_valid,
    input  logic [2:0]                 redirect_kind,
    input  logic [31:0]                redirect_pc,
    input  logic [31:0]                cp0_epc,
    input  logic [2:0]                 cp0_config_k0,
    input  logic                       tlb_we,
    input  logic [tlb_index_width-1:0] tlb_index,
    input  logic [18:0]                tlb_vpn2,
    input  logic [19:0]                tlb_pfn0,
    input  logic [19:0]                tlb_pfn1,
    input  logic                       tlb_v0,
    input  logic                       tlb_v1,
    input  logic [2:0]                 tlb_c,
    output logic                       inst_sram_req,
    output logic [31:0]                inst_sram_addr,
    output logic                       inst_sram_cached,
    input  logic                       inst_sram_addr_ok,
    input  logic                       inst_sram_data_ok,
    input  logic [31:0]                inst_sram_rdata,
    output logic                       inst_valid,
    output logic [31:0]                inst,
    output logic [31:0]                inst_pc,
    output logic                       inst_exception,
    output logic [4:0]                 inst_exccode,
    output logic                       inst_tlb_refill,
    input  logic                       decode_ready
);

    logic [31:0] fetch_vaddr;
    logic        mapped;
    logic [18:0] vpn2;
    logic        odd_page;
    logic        found;
    logic        v;
    logic [19:0] pfn;
    logic [2:0]  c;
    logic        slot_free;
    logic        issue_accepted;
    logic [31:0] issue_pc;
    logic        fault_valid;
    logic [4:0]  fault_exccode;
    logic        fault_refill;

    pre_if u_pre_if (
        .clk               (clk),
        .reset             (reset),
        .redirect_valid    (redirect_valid),
        .redirect_kind     (redirect_kind),
        .redirect_pc       (redirect_pc),
        .cp0_epc           (cp0_epc),
        .slot_free         (slot_free),
        .mapped            (mapped),
        .found             (found),
        .v                 (v),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .fetch_vaddr       (fetch_vaddr),
        .inst_sram_req     (inst_sram_req),
        .issue_accepted    (issue_accepted),
        .issue_pc          (issue_pc),
        .fault_valid       (fault_valid),
        .fault_exccode     (fault_exccode),
        .fault_refill      (fault_refill)
    );

    addr_trans u_addr_trans (
        .vaddr     (fetch_vaddr),
        .pfn       (pfn),
        .found     (found),
        .v         (v),
        .c         (c),
        .config_k0 (cp0_config_k0),
        .paddr     (inst_sram_addr),
        .mapped    (mapped),
        .cached    (inst_sram_cached),
        .vpn2      (vpn2),
        .odd_page  (odd_page)
    );

    itlb u_itlb (
        .clk      (clk),
        .reset    (reset),
        .we       (tlb_we),
        .windex   (tlb_index),
        .wvpn2    (tlb_vpn2),
        .wpfn0    (tlb_pfn0),
        .wpfn1    (tlb_pfn1),
        .wv0      (tlb_v0),
        .wv1      (tlb_v1),
        .wc       (tlb_c),
        .vpn2     (vpn2),
        .odd_page (odd_page),
        .found    (found),
        .v        (v),
        .pfn      (pfn),
        .c        (c)
    );

    if_stage u_if_stage (
        .clk               (clk),
        .reset             (reset),
        .redirect_valid    (redirect_valid),
        .issue_accepted    (issue_accepted),
        .issue_pc          (issue_pc),
        .fault_valid       (fault_valid),
        .fault_exccode     (fault_exccode),
        .fault_refill      (fault_refill),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .decode_ready      (decode_ready),
        .slot_free         (slot_free),
        .inst_valid        (inst_valid),
        .inst              (inst),
        .inst_pc           (inst_pc),
        .inst_exception    (inst_exception),
        .inst_exccode      (inst_exccode),
        .inst_tlb_refill   (inst_tlb_refill)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk
);

    // 4 ns period, first rising edge at 2 ns
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/fetch_unit_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_unit_tb import fetch_pkg::*; ();

    localparam int         n_rows       = 20;
    localparam int         wait_limit   = 64;
    localparam logic [2:0] no_redirect  = 3'd7;

    typedef struct packed {
        logic                       we;
        logic [tlb_index_width-1:0] index;
        logic [18:0]                vpn2;
        logic [19:0]                pfn0;
        logic [19:0]                pfn1;
        logic                       v0;
        logic                       v1;
        logic [2:0]                 c;
    } tlb_write_t;

    typedef struct packed {
        tlb_write_t  tlb;
        logic [2:0]  kind;
        logic [31:0] target;
        logic [2:0]  k0;
        logic [31:0] exp_pc;
        logic [31:0] exp_paddr;
        logic        exp_cached;
        logic        exp_exc;
        logic [4:0]  exp_code;
        logic        exp_refill;
    } row_t;

    localparam tlb_write_t no_write      = '0;
    // vpn2 0x200 covers 0x0040_0000 .. 0x0040_1fff
    localparam tlb_write_t write_pair    = '{1'b1, 2'd1, 19'h00200, 20'h12345, 20'h23456,
                                             1'b1, 1'b1, 3'd3};
    // odd half of 0x7fff_e000 is left invalid
    localparam tlb_write_t write_half    = '{1'b1, 2'd2, 19'h3FFFF, 20'h00ABC, 20'h00DEF,
                                             1'b1, 1'b0, 3'd2};
    localparam tlb_write_t write_rewrite = '{1'b1, 2'd1, 19'h00200, 20'h0F0F0, 20'h11111,
                                             1'b1, 1'b0, 3'd3};

    string row_name [n_rows] = '{
        "reset_fetch", "seq_1", "seq_2", "seq_3", "refill_vector", "general_vector",
        "eret_epc", "kseg0_cached", "kseg0_seq", "kseg0_uncached", "tlb_even",
        "tlb_odd", "tlb_uncached", "tlb_invalid", "tlb_miss", "misaligned",
        "restart_branch", "restart_seq", "tlb_rewrite", "rewrite_seq"
    };

    row_t rows [n_rows] = '{
        '{no_write, no_redirect, 32'h0, 3'd3,
          32'hBFC0_0000, 32'h1FC0_0000, 1'b0, 1'b0, 5'd0, 1'b0},
        '{no_write, no_redirect, 32'h0, 3'd3,
          32'hBFC0_0004, 32'h1FC0_0004, 1'b0, 1'b0, 5'd0, 1'b0},
        '{no_write, no_redirect, 32'h0, 3'd3,
          32'hBFC0_0008, 32'h1FC0_0008, 1'b0, 1'b0, 5'd0, 1'b0},
        '{no_write, no_redirect, 32'h0, 3'd3,
          32'hBFC0_000C, 32'h1FC0_000C, 1'b0, 1'b0, 5'd0, 1'b0},
        '{no_write, redirect_refill, 32'h0, 3'd3,
          32'hBFC0_0200, 32'h1FC0_0200, 1'b0, 1'b0, 5'd0, 1'b0},
        '{no_write, redirect_exception, 32'h0, 3'd3,
          32'hBFC0_0380, 32'h1FC0_0380, 1'b0, 1'b0, 5'd0, 1'b0},
        '{no_write, redirect_eret, 32'hBFC0_1000, 3'd3,
          32'hBFC0_1000, 32'h1FC0_1000, 1'b0, 1'b0, 5'd0, 1'b0},
        '{no_write, redirect_branch, 32'h8000_1000, 3'd3,
          32'h8000_1000, 32'h0000_1000, 1'b1, 1'b0, 5'd0, 1'b0},
        '{no_write, no_redirect, 32'h0, 3'd3,
          32'h8000_1004, 32'h0000_1004, 1'b1, 1'b0, 5'd0, 1'b0},
        '{no_write, redirect_refetch, 32'h8000_2000, 3'd2,
          32'h8000_2000, 32'h0000_2000, 1'b0, 1'b0, 5'd0, 1'b0},
        '{write_pair, redirect_branch, 32'h0040_0010, 3'd2,
          32'h0040_0010, 32'h1234_5010, 1'b1, 1'b0, 5'd0, 1'b0},
        '{no_write, redirect_branch, 32'h0040_1020, 3'd2,
          32'h0040_1020, 32'h2345_6020, 1'b1, 1'b0, 5'd0, 1'b0},
        '{write_half, redirect_branch, 32'h7FFF_E000, 3'd2,
          32'h7FFF_E000, 32'h00AB_C000, 1'b0, 1'b0, 5'd0, 1'b0},
        '{no_write, redirect_branch, 32'h7FFF_F000, 3'd2,
          32'h7FFF_F000, 32'h0, 1'b0, 1'b1, 5'd2, 1'b0},
        '{no_write, redirect_branch, 32'h1000_0000, 3'd2,
          32'h1000_0000, 32'h0, 1'b0, 1'b1, 5'd2, 1'b1},
        '{no_write, redirect_branch, 32'hBFC0_0002, 3'd2,
          32'hBFC0_0002, 32'h0, 1'b0, 1'b1, 5'd4, 1'b0},
        '{no_write, redirect_branch, 32'hBFC0_0100, 3'd2,
          32'hBFC0_0100, 32'h1FC0_0100, 1'b0, 1'b0, 5'd0, 1'b0},
        '{no_write, no_redirect, 32'h0, 3'd2,
          32'hBFC0_0104, 32'h1FC0_0104, 1'b0, 1'b0, 5'd0, 1'b0},
        '{write_rewrite, redirect_branch, 32'h0040_0004, 3'd2,
          32'h0040_0004, 32'h0F0F_0004, 1'b1, 1'b0, 5'd0, 1'b0},
        '{no_write, no_redirect, 32'h0, 3'd2,
          32'h0040_0008, 32'h0F0F_0008, 1'b1, 1'b0, 5'd0, 1'b0}
    };

    logic                       clk;
    logic                       reset;
    logic                       redirect_valid;
    logic [2:0]                 redirect_kind;
    logic [31:0]                redirect_pc;
    logic [31:0]                cp0_epc;
    logic [2:0]                 cp0_config_k0;
    logic                       tlb_we;
    logic [tlb_index_width-1:0] tlb_index;
    logic [18:0]                tlb_vpn2;
    logic [19:0]                tlb_pfn0;
    logic [19:0]                tlb_pfn1;
    logic                       tlb_v0;
    logic                       tlb_v1;
    logic [2:0]                 tlb_c;
    logic                       inst_sram_req;
    logic [31:0]                inst_sram_addr;
    logic                       inst_sram_cached;
    logic                       inst_sram_addr_ok = 1'b0;
    logic                       inst_sram_data_ok = 1'b0;
    logic [31:0]                inst_sram_rdata   = '0;
    logic                       inst_valid;
    logic [31:0]                inst;
    logic [31:0]                inst_pc;
    logic                       inst_exception;
    logic [4:0]                 inst_exccode;
    logic                       inst_tlb_refill;
    logic                       decode_ready;

    // memory model state
    logic [31:0] pending [$];
    logic        cached_at [logic [31:0]];
    int          addr_wait = 0;
    int          data_wait = 0;
    int          req_count = 0;

    int errors      = 0;
    int rows_passed = 0;
    int rows_failed = 0;
    bit timed_out   = 1'b0;

    tb_clock i_clock (
        .clk (clk)
    );

    fetch_unit i_dut (.*);

    // handshakes are seen on the rising edge, where req and addr have settled
    always @(posedge clk) begin
        if (inst_sram_data_ok) begin
            void'(pending.pop_front());
            data_wait = int'($urandom % 4);
        end else if ((pending.size() > 0) && (data_wait > 0)) begin
            data_wait--;
        end
        if (inst_sram_req) begin
            req_count++;
            if (inst_sram_addr_ok) begin
                if (pending.size() == 0) begin
                    data_wait = int'($urandom % 4);
                end
                pending.push_back(inst_sram_addr);
                cached_at[inst_sram_addr] = inst_sram_cached;
                addr_wait = int'($urandom % 4);
            end else if (addr_wait > 0) begin
                addr_wait--;
            end
        end
    end

    // responses change on the falling edge; the word is the inverted physical address
    always @(negedge clk) begin
        inst_sram_addr_ok = (addr_wait == 0);
        if ((pending.size() > 0) && (data_wait == 0)) begin
            inst_sram_data_ok = 1'b1;
            inst_sram_rdata   = ~pending[0];
        end else begin
            inst_sram_data_ok = 1'b0;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic wait_valid(input string name);
        int waited;
        waited = 0;
        while (!inst_valid && (waited < wait_limit)) begin
            @(negedge clk);
            waited++;
        end
        if (!inst_valid) begin
            $display("timeout in %s: no instruction was delivered", name);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    // after a fault nothing may be requested or delivered
    task automatic check_halt(input string name);
        int reqs;
        reqs = req_count;
        repeat (8) @(negedge clk);
        check({name, " halt req"}, 32'(reqs), 32'(req_count));
        check({name, " halt valid"}, 32'd0, 32'(inst_valid));
    endtask

    task automatic apply_row(input int i);
        row_t        r;
        int          errors_before;
        int          hold;
        logic [31:0] got_pc;
        logic [31:0] got_inst;
        logic        got_exc;
        logic [4:0]  got_code;
        logic        got_refill;
        logic        seen_cached;
        r = rows[i];
        errors_before = errors;
        cp0_config_k0 = r.k0;
        tlb_we        = r.tlb.we;
        tlb_index     = r.tlb.index;
        tlb_vpn2      = r.tlb.vpn2;
        tlb_pfn0      = r.tlb.pfn0;
        tlb_pfn1      = r.tlb.pfn1;
        tlb_v0        = r.tlb.v0;
        tlb_v1        = r.tlb.v1;
        tlb_c         = r.tlb.c;
        @(negedge clk);
        tlb_we = 1'b0;
        if (r.kind != no_redirect) begin
            redirect_valid = 1'b1;
            redirect_kind  = r.kind;
            // only the source that the kind selects holds the target
            redirect_pc    = (r.kind == redirect_eret) ? ~r.target : r.target;
            cp0_epc        = (r.kind == redirect_eret) ? r.target : ~r.target;
            @(negedge clk);
            redirect_valid = 1'b0;
        end
        wait_valid(row_name[i]);
        if (!timed_out) begin
            got_pc     = inst_pc;
            got_inst   = inst;
            got_exc    = inst_exception;
            got_code   = inst_exccode;
            got_refill = inst_tlb_refill;
            // decode stalls for a while and the output must not move
            hold = int'($urandom % 4);
            repeat (hold) begin
                @(negedge clk);
                check({row_name[i], " held valid"}, 32'd1, 32'(inst_valid));
                check({row_name[i], " held pc"}, got_pc, inst_pc);
                check({row_name[i], " held inst"}, got_inst, inst);
            end
            decode_ready = 1'b1;
            @(negedge clk);
            decode_ready = 1'b0;
            check({row_name[i], " pc"}, r.exp_pc, got_pc);
            check({row_name[i], " exception"}, 32'(r.exp_exc), 32'(got_exc));
            if (r.exp_exc) begin
                check({row_name[i], " exccode"}, 32'(r.exp_code), 32'(got_code));
                check({row_name[i], " refill"}, 32'(r.exp_refill), 32'(got_refill));
                check_halt(row_name[i]);
            end else begin
                seen_cached = cached_at.exists(r.exp_paddr) ? cached_at[r.exp_paddr] : 1'bx;
                check({row_name[i], " inst"}, ~r.exp_paddr, got_inst);
                check({row_name[i], " cached"}, 32'(r.exp_cached), 32'(seen_cached));
            end
        end
        if (errors == errors_before) begin
            $display("ok   %s", row_name[i]);
            rows_passed++;
        end else begin
            $display("fail %s", row_name[i]);
            rows_failed++;
        end
    endtask

    initial begin
        void'($urandom(32'h5ade_fdf8));
        reset          = 1'b1;
        redirect_valid = 1'b0;
        redirect_kind  = redirect_exception;
        redirect_pc    = '0;
        cp0_epc        = '0;
        cp0_config_k0  = 3'd3;
        tlb_we         = 1'b0;
        tlb_index      = '0;
        tlb_vpn2       = '0;
        tlb_pfn0       = '0;
        tlb_pfn1       = '0;
        tlb_v0         = 1'b0;
        tlb_v1         = 1'b0;
        tlb_c          = '0;
        decode_ready   = 1'b0;
        repeat (5) begin
            @(negedge clk);
            check("reset inst_valid", 32'd0, 32'(inst_valid));
        end
        reset = 1'b0;
        check("reset req", 32'd0, 32'(req_count));
        for (int i = 0; (i < n_rows) && !timed_out; i++) begin
            apply_row(i);
        end
        $display("rows passed %0d, rows failed %0d", rows_passed, rows_failed);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
source/fetch_pkg.sv
source/itlb.sv
source/addr_trans.sv
source/pre_if.sv
source/if_stage.sv
source/fetch_unit.sv
testbench/tb_clock.sv
testbench/fetch_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module fetch_unit_tb
./obj_dir/Vfetch_unit_tb | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
grep -q "TESTS PASSED" sim.log
